//--- dc_pkg.sv
package dc_pkg;

   localparam int DATA_W    = 8;    // register and alu width
   localparam int MI_W      = 16;   // microinstruction word
   localparam int FIELD_W   = 4;    // register field
   localparam int G_W       = 3;    // bank register
   localparam int PSW_W     = 4;    // n z v c
   localparam int REG_COUNT = 26;   // 16 banked/fixed plus 10 fixed

   localparam int PSW_C = 0;        // carry or borrow
   localparam int PSW_V = 1;        // signed overflow
   localparam int PSW_Z = 2;        // zero
   localparam int PSW_N = 3;        // negative

   localparam int OP_MSB  = 15;     // opcode field
   localparam int OP_LSB  = 12;
   localparam int FA_MSB  = 3;      // register a field
   localparam int FA_LSB  = 0;
   localparam int FB_MSB  = 7;      // register b field
   localparam int FB_LSB  = 4;
   localparam int LIT_MSB = 11;     // literal overlaps field b
   localparam int LIT_LSB = 4;

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_MOV  = 4'h5,
      OP_LIT  = 4'h6,
      OP_SETG = 4'h7,
      OP_OUT  = 4'h8                // 9 to f are no-ops
   } opcode_e;

   typedef enum logic [1:0] {
      ST_IDLE     = 2'd0,
      ST_EXEC     = 2'd1,
      ST_ACK      = 2'd2,
      ST_WAIT_LOW = 2'd3
   } mi_state_e;

endpackage

//--- mi_control.sv
module mi_control
(
   input  logic                          c1,       // clock
   input  logic                          arst_n,   // async reset
   input  logic                          mi_req,   // handshake request
   input  logic [dc_pkg::MI_W-1:0]       mi,       // microinstruction word
   input  logic [dc_pkg::DATA_W-1:0]     ra,       // register port a
   input  logic [dc_pkg::DATA_W-1:0]     rb,       // register port b
   output logic                          mi_ack,   // handshake acknowledge
   output logic                          exec,     // one-cycle execute strobe
   output dc_pkg::opcode_e               op,       // decoded opcode
   output logic [dc_pkg::FIELD_W-1:0]    fa_sel,   // field a
   output logic [dc_pkg::FIELD_W-1:0]    fb_sel,   // field b
   output logic [dc_pkg::DATA_W-1:0]     lit,      // literal
   output logic [2*dc_pkg::DATA_W-1:0]   ad        // output data latch
);

   dc_pkg::mi_state_e           state;
   dc_pkg::mi_state_e           state_nxt;
   logic [dc_pkg::MI_W-1:0]     mir;              // held microinstruction
   logic                        capture;          // accept new word

   assign capture = (state == dc_pkg::ST_IDLE) & mi_req;

   // handshake FSM
   always_comb
   begin
      state_nxt = state;
      case (state)
         dc_pkg::ST_IDLE:
            if (mi_req)
               state_nxt = dc_pkg::ST_EXEC;
         dc_pkg::ST_EXEC:
            state_nxt = dc_pkg::ST_ACK;                 // writes land here
         dc_pkg::ST_ACK:
            if (mi_req)
               state_nxt = dc_pkg::ST_WAIT_LOW;
            else
               state_nxt = dc_pkg::ST_IDLE;
         dc_pkg::ST_WAIT_LOW:
            if (!mi_req)
               state_nxt = dc_pkg::ST_IDLE;          // hold ack while req high
         default:
            state_nxt = dc_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge c1 or negedge arst_n)
   begin
      if (!arst_n)
         state <= dc_pkg::ST_IDLE;
      else
         state <= state_nxt;
   end

   assign exec   = (state == dc_pkg::ST_EXEC);
   assign mi_ack = (state == dc_pkg::ST_ACK) | (state == dc_pkg::ST_WAIT_LOW);

   // microinstruction register, loaded once per request
   always_ff @(posedge c1 or negedge arst_n)
   begin
      if (!arst_n)
         mir <= '0;
      else if (capture)
         mir <= mi;
   end

   // field split of the held word
   assign op     = dc_pkg::opcode_e'(mir[dc_pkg::OP_MSB:dc_pkg::OP_LSB]);
   assign fa_sel = mir[dc_pkg::FA_MSB:dc_pkg::FA_LSB];
   assign fb_sel = mir[dc_pkg::FB_MSB:dc_pkg::FB_LSB];
   assign lit    = mir[dc_pkg::LIT_MSB:dc_pkg::LIT_LSB];

   // B operand goes out on the high byte, A on the low byte
   always_ff @(posedge c1 or negedge arst_n)
   begin
      if (!arst_n)
         ad <= '0;
      else if (exec && (op == dc_pkg::OP_OUT))
         ad <= {rb, ra};
   end

endmodule

//--- reg_file.sv
module reg_file
(
   input  logic                          c1,       // clock
   input  logic                          arst_n,   // async reset
   input  logic                          exec,     // execute strobe
   input  dc_pkg::opcode_e               op,       // current opcode
   input  logic [dc_pkg::FIELD_W-1:0]    fa_sel,   // field a
   input  logic [dc_pkg::FIELD_W-1:0]    fb_sel,   // field b
   input  logic [dc_pkg::DATA_W-1:0]     lit,      // literal
   input  logic [dc_pkg::DATA_W-1:0]     result,   // alu result
   output logic [dc_pkg::DATA_W-1:0]     ra,       // read port a
   output logic [dc_pkg::DATA_W-1:0]     rb        // read port b
);

   localparam int IDX_W = $clog2(dc_pkg::REG_COUNT);

   logic [dc_pkg::DATA_W-1:0]   regs [dc_pkg::REG_COUNT];
   logic [dc_pkg::G_W-1:0]      g;                // bank register
   logic [IDX_W-1:0]            idx_a;
   logic [IDX_W-1:0]            idx_b;
   logic                        reg_we;
   logic                        g_we;

   // field to register index through the current bank
   function automatic logic [IDX_W-1:0] map_reg
   (
      input logic [dc_pkg::FIELD_W-1:0] f,
      input logic [dc_pkg::G_W-1:0]     bank
   );
      if (f == 4'd0)
         map_reg = IDX_W'({bank, 1'b0});              // 2G
      else if (f == 4'd1)
         map_reg = IDX_W'({bank, 1'b1});              // 2G+1
      else
         map_reg = IDX_W'(dc_pkg::REG_COUNT + 1 - int'(f));  // fixed, 25 down to 12
   endfunction

   assign idx_a = map_reg(fa_sel, g);
   assign idx_b = map_reg(fb_sel, g);

   assign ra = regs[idx_a];
   assign rb = regs[idx_b];

   assign reg_we = exec && (op inside {dc_pkg::OP_ADD, dc_pkg::OP_SUB, dc_pkg::OP_AND,
                                       dc_pkg::OP_OR, dc_pkg::OP_XOR, dc_pkg::OP_MOV,
                                       dc_pkg::OP_LIT});
   assign g_we   = exec && (op == dc_pkg::OP_SETG);

   always_ff @(posedge c1 or negedge arst_n)
   begin
      if (!arst_n)
         g <= '0;
      else if (g_we)
         g <= lit[dc_pkg::G_W-1:0];
   end

   // result always lands in the A register
   always_ff @(posedge c1 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < dc_pkg::REG_COUNT; i++)
            regs[i] <= '0;
      end
      else if (reg_we)
         regs[idx_a] <= result;
   end

endmodule

//--- alu_psw.sv
module alu_psw
(
   input  logic                          c1,       // clock
   input  logic                          arst_n,   // async reset
   input  logic                          exec,     // execute strobe
   input  dc_pkg::opcode_e               op,       // current opcode
   input  logic [dc_pkg::DATA_W-1:0]     ra,       // operand a
   input  logic [dc_pkg::DATA_W-1:0]     rb,       // operand b
   input  logic [dc_pkg::DATA_W-1:0]     lit,      // literal
   output logic [dc_pkg::DATA_W-1:0]     result,   // value for register a
   output logic [dc_pkg::PSW_W-1:0]      psw       // status flags
);

   logic                        sub;
   logic                        is_arith;
   logic                        is_logic;
   logic [dc_pkg::DATA_W-1:0]   fb;               // b after inversion
   logic [dc_pkg::DATA_W-1:0]   prop;
   logic [dc_pkg::DATA_W-1:0]   gen;
   logic [dc_pkg::DATA_W-1:0]   carry;            // carry out of each bit
   logic [dc_pkg::DATA_W-1:0]   sum;

   assign sub      = (op == dc_pkg::OP_SUB);
   assign is_arith = (op == dc_pkg::OP_ADD) | sub;
   assign is_logic = op inside {dc_pkg::OP_AND, dc_pkg::OP_OR, dc_pkg::OP_XOR,
                                dc_pkg::OP_MOV, dc_pkg::OP_LIT};

   // a + ~b + 1 for subtract
   assign fb   = sub ? ~rb : rb;
   assign prop = ra ^ fb;
   assign gen  = ra & fb;

   always_comb
   begin
      carry[0] = gen[0] | (prop[0] & sub);
      for (int i = 1; i < dc_pkg::DATA_W; i++)
         carry[i] = gen[i] | (prop[i] & carry[i-1]);
   end

   assign sum = prop ^ {carry[dc_pkg::DATA_W-2:0], sub};

   always_comb
   begin
      case (op)
         dc_pkg::OP_ADD, dc_pkg::OP_SUB: result = sum;
         dc_pkg::OP_AND:                 result = ra & rb;
         dc_pkg::OP_OR:                  result = ra | rb;
         dc_pkg::OP_XOR:                 result = ra ^ rb;
         dc_pkg::OP_MOV:                 result = rb;
         dc_pkg::OP_LIT:                 result = lit;
         default:                        result = ra;   // not written back
      endcase
   end

   always_ff @(posedge c1 or negedge arst_n)
   begin
      if (!arst_n)
         psw <= '0;
      else if (exec && (is_arith || is_logic))
      begin
         if (is_arith)
            psw[dc_pkg::PSW_C] <= carry[dc_pkg::DATA_W-1] ^ sub;  // borrow on sub
         psw[dc_pkg::PSW_V] <= is_arith &
                               (carry[dc_pkg::DATA_W-1] ^ carry[dc_pkg::DATA_W-2]);
         psw[dc_pkg::PSW_Z] <= (result == '0);
         psw[dc_pkg::PSW_N] <= result[dc_pkg::DATA_W-1];
      end
   end

endmodule

//--- dc_top.sv
module dc_top
(
   input  logic                          c1,       // clock
   input  logic                          arst_n,   // async reset, active low
   input  logic                          mi_req,   // handshake request
   input  logic [dc_pkg::MI_W-1:0]       mi,       // microinstruction word
   output logic                          mi_ack,   // handshake acknowledge
   output logic [2*dc_pkg::DATA_W-1:0]   ad,       // output data latch
   output logic [dc_pkg::PSW_W-1:0]      psw       // processor status word
);

   logic                        exec;
   dc_pkg::opcode_e             op;
   logic [dc_pkg::FIELD_W-1:0]  fa_sel;
   logic [dc_pkg::FIELD_W-1:0]  fb_sel;
   logic [dc_pkg::DATA_W-1:0]   lit;
   logic [dc_pkg::DATA_W-1:0]   ra;
   logic [dc_pkg::DATA_W-1:0]   rb;
   logic [dc_pkg::DATA_W-1:0]   result;

   mi_control u_mi_control
   (
      .c1(c1),
      .arst_n(arst_n),
      .mi_req(mi_req),
      .mi(mi),
      .ra(ra),
      .rb(rb),
      .mi_ack(mi_ack),
      .exec(exec),
      .op(op),
      .fa_sel(fa_sel),
      .fb_sel(fb_sel),
      .lit(lit),
      .ad(ad)
   );

   reg_file u_reg_file
   (
      .c1(c1),
      .arst_n(arst_n),
      .exec(exec),
      .op(op),
      .fa_sel(fa_sel),
      .fb_sel(fb_sel),
      .lit(lit),
      .result(result),
      .ra(ra),
      .rb(rb)
   );

   alu_psw u_alu_psw
   (
      .c1(c1),
      .arst_n(arst_n),
      .exec(exec),
      .op(op),
      .ra(ra),
      .rb(rb),
      .lit(lit),
      .result(result),
      .psw(psw)
   );

endmodule

//--- tb_clock.sv
module tb_clock
(
   output logic c1,       // clock
   output logic arst_n    // async reset, active low
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD = 10;   // 20 ns period

   initial
   begin
      c1 = 1'b0;
      forever #HALF_PERIOD c1 = ~c1;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (10) @(posedge c1);
      #2 arst_n = 1'b1;               // release just after the edge
   end

endmodule

//--- tb_top.sv
module tb_top;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT_CYCLES = 50;

   logic         c1;
   logic         arst_n;
   logic         mi_req;
   logic [15:0]  mi;
   logic         mi_ack;
   logic [15:0]  ad;
   logic [3:0]   psw;

   logic [7:0]   m_regs [26];         // reference model
   logic [2:0]   m_g;
   logic [3:0]   m_psw;
   logic [15:0]  m_ad;

   integer       seed;
   int           err_val;
   int           err_timeout;

   dc_pkg::opcode_e rand_ops [7] = '{dc_pkg::OP_ADD, dc_pkg::OP_SUB, dc_pkg::OP_AND,
                                     dc_pkg::OP_OR, dc_pkg::OP_XOR, dc_pkg::OP_MOV,
                                     dc_pkg::OP_LIT};

   tb_clock u_tb_clock (.c1(c1), .arst_n(arst_n));

   dc_top u_dc_top
   (
      .c1(c1),
      .arst_n(arst_n),
      .mi_req(mi_req),
      .mi(mi),
      .mi_ack(mi_ack),
      .ad(ad),
      .psw(psw)
   );

   // field value to register number through the bank
   function automatic int map_index(input logic [3:0] f, input logic [2:0] bank);
      if (f == 4'd0)
         map_index = 2 * int'(bank);
      else if (f == 4'd1)
         map_index = 2 * int'(bank) + 1;
      else
         map_index = 27 - int'(f);
   endfunction

   task automatic model_exec(input logic [15:0] word);
      dc_pkg::opcode_e op;
      int              ia;
      logic [7:0]      a;
      logic [7:0]      b;
      logic [7:0]      res;
      logic [8:0]      full;
      logic            wr;
      op   = dc_pkg::opcode_e'(word[dc_pkg::OP_MSB:dc_pkg::OP_LSB]);
      ia   = map_index(word[dc_pkg::FA_MSB:dc_pkg::FA_LSB], m_g);
      a    = m_regs[ia];
      b    = m_regs[map_index(word[dc_pkg::FB_MSB:dc_pkg::FB_LSB], m_g)];
      res  = a;
      wr   = 1'b1;
      if (op inside {dc_pkg::OP_AND, dc_pkg::OP_OR, dc_pkg::OP_XOR, dc_pkg::OP_MOV,
                     dc_pkg::OP_LIT})
         m_psw[dc_pkg::PSW_V] = 1'b0;                       // logic ops clear overflow
      case (op)
         dc_pkg::OP_ADD:
         begin
            full = {1'b0, a} + {1'b0, b};
            res  = full[7:0];
            m_psw[dc_pkg::PSW_C] = full[8];
            m_psw[dc_pkg::PSW_V] = (a[7] == b[7]) && (res[7] != a[7]);
         end
         dc_pkg::OP_SUB:
         begin
            res = a - b;
            m_psw[dc_pkg::PSW_C] = (a < b);                   // borrow
            m_psw[dc_pkg::PSW_V] = (a[7] != b[7]) && (res[7] != a[7]);
         end
         dc_pkg::OP_AND:  res = a & b;
         dc_pkg::OP_OR:   res = a | b;
         dc_pkg::OP_XOR:  res = a ^ b;
         dc_pkg::OP_MOV:  res = b;
         dc_pkg::OP_LIT:  res = word[dc_pkg::LIT_MSB:dc_pkg::LIT_LSB];
         dc_pkg::OP_SETG: {m_g, wr} = {word[6:4], 1'b0};     // lit bits 2:0
         dc_pkg::OP_OUT:  {m_ad, wr} = {b, a, 1'b0};
         default:         wr = 1'b0;
      endcase
      if (wr)
      begin
         m_psw[dc_pkg::PSW_Z] = (res == 8'h00);
         m_psw[dc_pkg::PSW_N] = res[7];
         m_regs[ia] = res;
      end
   endtask

   task automatic finish_run;
      $display("errors: %0d value mismatches, %0d timeouts", err_val, err_timeout);
      if (err_val == 0 && err_timeout == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   endtask

   // sampled 2 ns after each edge, where outputs are settled
   task automatic wait_ack(input logic level, output int cycles);
      cycles = 0;
      while (mi_ack !== level || cycles == 0)
      begin
         @(posedge c1);
         #2;
         cycles++;
         if (mi_ack !== level && cycles >= TIMEOUT_CYCLES)
         begin
            $display("timeout: mi_ack did not reach %b within %0d cycles", level, cycles);
            err_timeout++;
            finish_run();
         end
      end
   endtask

   task automatic run_instr(input logic [15:0] word, input int hold);
      int cycles;
      mi     = word;
      mi_req = 1'b1;
      wait_ack(1'b1, cycles);
      if (cycles != 2)
      begin
         $display("[ERROR] %0t mi_ack latency expected 2 got %0d", $time, cycles);
         err_val++;
      end
      model_exec(word);
      if (ad !== m_ad)
      begin
         $display("[ERROR] %0t ad expected 0x%04h got 0x%04h", $time, m_ad, ad);
         err_val++;
      end
      if (psw !== m_psw)
      begin
         $display("[ERROR] %0t psw expected 0x%0h got 0x%0h", $time, m_psw, psw);
         err_val++;
      end
      repeat (hold)
      begin
         @(posedge c1);
         #2;
         if (mi_ack !== 1'b1)
         begin
            $display("[ERROR] %0t mi_ack expected 1 got %b", $time, mi_ack);
            err_val++;
         end
      end
      mi_req = 1'b0;
      wait_ack(1'b0, cycles);
      if (cycles != 1)
      begin
         $display("[ERROR] %0t mi_ack release latency expected 1 got %0d", $time, cycles);
         err_val++;
      end
   endtask

   initial
   begin
      int          cnt;
      int          r;
      logic [15:0] word;
      logic [15:0] banked_ad;
      logic [2:0]  bank;
      seed        = 25448;
      mi_req      = 1'b0;
      mi          = 16'h0000;
      err_val     = 0;
      err_timeout = 0;
      for (int i = 0; i < 26; i++)
         m_regs[i] = 8'h00;
      m_g   = 3'd0;
      m_psw = 4'h0;
      m_ad  = 16'h0000;
      cnt   = 0;
      while (arst_n !== 1'b1)
      begin
         @(posedge c1);
         cnt++;
         if (cnt > TIMEOUT_CYCLES)
         begin
            $display("timeout: reset was never released");
            err_timeout++;
            finish_run();
         end
      end
      #2;
      if ({mi_ack, ad, psw} !== 21'd0)
      begin
         $display("[ERROR] %0t mi_ack/ad/psw expected 0 got %b/0x%04h/0x%0h",
                  $time, mi_ack, ad, psw);
         err_val++;
      end
      run_instr({dc_pkg::OP_LIT, 8'h5a, 4'h2}, 5);            // request held high
      repeat (8)
      begin
         r = $random(seed);
         run_instr({dc_pkg::OP_LIT, r[7:0], r[11:8]}, 0);
         run_instr({dc_pkg::OP_OUT, 4'h0, r[3:0], r[11:8]}, 0);
         if (ad[7:0] !== r[7:0])
         begin
            $display("[ERROR] %0t ad[7:0] expected 0x%02h got 0x%02h", $time, r[7:0], ad[7:0]);
            err_val++;
         end
      end
      repeat (400)
      begin
         r    = $random(seed);
         word = {rand_ops[$unsigned(r) % 7], r[27:16]};
         run_instr(word, 0);
         run_instr({dc_pkg::OP_OUT, 4'h0, word[7:0]}, 0);  // same fields
      end
      for (int i = 0; i < 16; i++)
      begin
         r    = $random(seed);
         bank = (i < 2) ? 3'(6 + i) : r[2:0];                // banks 6 and 7 first
         run_instr({dc_pkg::OP_SETG, 5'b00000, bank, 4'h0}, 0);
         run_instr({dc_pkg::OP_LIT, r[15:8], 4'h0}, 0);
         run_instr({dc_pkg::OP_LIT, r[23:16], 4'h1}, 0);
         run_instr({dc_pkg::OP_OUT, 4'h0, 4'h1, 4'h0}, 0);
         banked_ad = {r[23:16], r[15:8]};                     // registers 2G+1 and 2G
         if (bank >= 3'd6)
         begin
            run_instr({dc_pkg::OP_OUT, 4'h0, (bank == 3'd6) ? 8'hef : 8'hcd}, 0);
            if (ad !== banked_ad)
            begin
               $display("[ERROR] %0t ad alias expected 0x%04h got 0x%04h", $time, banked_ad, ad);
               err_val++;
            end
         end
      end
      finish_run();
   end

endmodule

//--- verilog.f
dc_pkg.sv
mi_control.sv
reg_file.sv
alu_psw.sv
dc_top.sv
tb_clock.sv
tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module tb_top -f verilog.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
